/* list.f */
verilog/ifm_buffer_pkg.sv
verilog/ifm_unit_ram.sv
verilog/ifm_bank_array.sv
verilog/prev_layer_port.sv
verilog/next_layer_port.sv
verilog/ifm_buffer.sv
tb/tb_ifm_buffer.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
	--top-module tb_ifm_buffer \
	-f list.f \
	-o sim_ifm_buffer

./obj_dir/sim_ifm_buffer | tee sim.log

if grep -q ">>> FAIL" sim.log; then
	echo "simulation reported failure"
	exit 1
fi
if ! grep -q ">>> PASS" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
echo "simulation passed"

/* tb/tb_ifm_buffer.sv */
`timescale 1ns/100ps

module tb_ifm_buffer;

	localparam int N_OPS = 400;
	localparam int FILL_CYCLES = 4 * 48 + 16; // fill, read-back and rotation of every bank
	localparam int MARGIN_CYCLES = 100;
	localparam int CLK_PERIOD = 40;
	localparam int WATCHDOG_CYCLES = N_OPS + FILL_CYCLES + MARGIN_CYCLES;

	logic                       clk = 1'b0;
	logic                       reset;
	ifm_buffer_pkg::bank_idx_t  ifm_sel;
	ifm_buffer_pkg::prev_req_t  prev_req;
	ifm_buffer_pkg::unit_data_t data_in;
	ifm_buffer_pkg::next_req_t  next_req;
	ifm_buffer_pkg::unit_data_t prev_rd_data;
	logic                       prev_rd_valid;
	ifm_buffer_pkg::unit_data_t next_rd_data_a;
	ifm_buffer_pkg::unit_data_t next_rd_data_b;
	logic                       next_rd_valid_a;
	logic                       next_rd_valid_b;

	// reference copy of every word of every unit memory
	ifm_buffer_pkg::word_t model [ifm_buffer_pkg::NUM_BANKS]
		[ifm_buffer_pkg::NUM_UNITS][ifm_buffer_pkg::IFM_WORDS];

	// expected results of the reads issued in the previous cycle
	logic                       exp_prev_valid = 1'b0;
	logic                       exp_a_valid = 1'b0;
	logic                       exp_b_valid = 1'b0;
	ifm_buffer_pkg::unit_data_t exp_prev_data;
	ifm_buffer_pkg::unit_data_t exp_a_data;
	ifm_buffer_pkg::unit_data_t exp_b_data;
	logic                       have_prev = 1'b0;
	logic                       have_a = 1'b0;
	logic                       have_b = 1'b0;
	ifm_buffer_pkg::unit_data_t last_prev;
	ifm_buffer_pkg::unit_data_t last_a;
	ifm_buffer_pkg::unit_data_t last_b;

	ifm_buffer_pkg::bank_idx_t  cur_sel = '0;
	logic [31:0]                lcg_state = 32'd22973;
	int                         data_errors = 0;
	int                         valid_errors = 0;

	always #(CLK_PERIOD / 2) clk = ~clk;

	ifm_buffer dut (
		.clk             (clk),
		.reset           (reset),
		.ifm_sel         (ifm_sel),
		.prev_req        (prev_req),
		.data_in         (data_in),
		.next_req        (next_req),
		.prev_rd_data    (prev_rd_data),
		.prev_rd_valid   (prev_rd_valid),
		.next_rd_data_a  (next_rd_data_a),
		.next_rd_data_b  (next_rd_data_b),
		.next_rd_valid_a (next_rd_valid_a),
		.next_rd_valid_b (next_rd_valid_b)
	);

	function automatic logic [15:0] rand16();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[31:16]; // upper bits have the longer period
	endfunction

	function automatic ifm_buffer_pkg::unit_data_t rand_data();
		ifm_buffer_pkg::unit_data_t words;
		for (int u = 0; u < ifm_buffer_pkg::NUM_UNITS; u++)
			words[u] = rand16();
		return words;
	endfunction

	function automatic ifm_buffer_pkg::unit_data_t read_model(
		input ifm_buffer_pkg::bank_idx_t bank,
		input ifm_buffer_pkg::addr_t     addr
	);
		ifm_buffer_pkg::unit_data_t words;
		for (int u = 0; u < ifm_buffer_pkg::NUM_UNITS; u++)
			words[u] = model[bank][u][addr];
		return words;
	endfunction

	task automatic check_read_port(
		input string                      port_name,
		input logic                       valid,
		input logic                       exp_valid,
		input ifm_buffer_pkg::unit_data_t data,
		input ifm_buffer_pkg::unit_data_t exp_data,
		inout logic                       have_last,
		inout ifm_buffer_pkg::unit_data_t last_data
	);
		if (valid !== exp_valid)
		begin
			valid_errors++;
			if (exp_valid)
				$display("%s read at %0t did not raise its valid flag", port_name, $time);
			else
				$display("%s valid flag high at %0t with no read issued", port_name, $time);
		end
		if (exp_valid)
		begin
			if (data !== exp_data)
			begin
				data_errors++;
				$display("[ERROR] %0t %s read data %h, expected %h",
					$time, port_name, data, exp_data);
			end
			have_last = 1'b1;
			last_data = exp_data;
		end
		else if (have_last && data !== last_data)
		begin
			data_errors++;
			$display("[ERROR] %0t %s data changed to %h with no read, expected to hold %h",
				$time, port_name, data, last_data);
		end
	endtask

	// called 5 ns after an edge, the request is taken at the next edge
	task automatic drive_cycle(
		input ifm_buffer_pkg::bank_idx_t  sel,
		input ifm_buffer_pkg::prev_req_t  pr,
		input ifm_buffer_pkg::unit_data_t din,
		input ifm_buffer_pkg::next_req_t  nr
	);
		ifm_buffer_pkg::bank_idx_t trail;
		trail = sel - 2'd1;
		ifm_sel = sel;
		prev_req = pr;
		data_in = din;
		next_req = nr;
		cur_sel = sel;

		// expected words are taken before this cycle's write lands
		exp_prev_valid = pr.rd_en;
		if (pr.rd_en)
			exp_prev_data = read_model(sel, pr.rd_addr);
		exp_a_valid = nr.rd_en_a;
		if (nr.rd_en_a)
			exp_a_data = read_model(trail, nr.addr_a);
		exp_b_valid = nr.rd_en_b;
		if (nr.rd_en_b)
			exp_b_data = read_model(trail, nr.addr_b);
		if (pr.wr_en)
		begin
			for (int u = 0; u < ifm_buffer_pkg::NUM_UNITS; u++)
				model[sel][u][pr.wr_addr] = din[u];
		end

		@(posedge clk);
		#5;
		check_read_port("previous-layer", prev_rd_valid, exp_prev_valid, prev_rd_data,
			exp_prev_data, have_prev, last_prev);
		check_read_port("next-layer A", next_rd_valid_a, exp_a_valid, next_rd_data_a,
			exp_a_data, have_a, last_a);
		check_read_port("next-layer B", next_rd_valid_b, exp_b_valid, next_rd_data_b,
			exp_b_data, have_b, last_b);
	endtask

	task automatic fill_and_rotate();
		ifm_buffer_pkg::prev_req_t pr;
		ifm_buffer_pkg::next_req_t nr;
		logic [15:0]               r;
		for (int b = 0; b < ifm_buffer_pkg::NUM_BANKS; b++)
		begin
			for (int a = 0; a < ifm_buffer_pkg::IFM_WORDS; a++)
			begin
				pr = '0;
				pr.wr_en = 1'b1;
				pr.wr_addr = ifm_buffer_pkg::addr_t'(a);
				drive_cycle(ifm_buffer_pkg::bank_idx_t'(b), pr, rand_data(), '0);
			end
			for (int a = 0; a < ifm_buffer_pkg::IFM_WORDS; a++)
			begin
				pr = '0;
				pr.rd_en = 1'b1;
				pr.rd_addr = ifm_buffer_pkg::addr_t'(a);
				drive_cycle(ifm_buffer_pkg::bank_idx_t'(b), pr, '0, '0);
			end
			// the select moves on and the next layer reads the bank just filled
			for (int i = 0; i < ifm_buffer_pkg::IFM_WORDS; i++)
			begin
				r = rand16();
				nr = '0;
				nr.rd_en_a = 1'b1;
				nr.rd_en_b = 1'b1;
				nr.addr_a = r[3:0];
				nr.addr_b = r[7:4];
				drive_cycle(ifm_buffer_pkg::bank_idx_t'(b + 1), '0, '0, nr);
			end
		end
	endtask

	task automatic read_during_write();
		ifm_buffer_pkg::prev_req_t pr;
		pr = '0;
		pr.wr_en = 1'b1;
		pr.rd_en = 1'b1;
		pr.wr_addr = 4'd5;
		pr.rd_addr = 4'd5;
		drive_cycle(2'd2, pr, rand_data(), '0); // returns the old word
		pr = '0;
		pr.rd_en = 1'b1;
		pr.rd_addr = 4'd5;
		drive_cycle(2'd2, pr, '0, '0);
	endtask

	task automatic random_mix();
		ifm_buffer_pkg::prev_req_t pr;
		ifm_buffer_pkg::next_req_t nr;
		ifm_buffer_pkg::bank_idx_t sel;
		logic [15:0]               r;
		logic [15:0]               r2;
		for (int i = 0; i < N_OPS; i++)
		begin
			r = rand16();
			r2 = rand16();
			sel = cur_sel + 2'd1 + (r[1:0] % 2'd3); // never the same select twice
			pr.wr_en = r[2];
			pr.rd_en = r[3];
			pr.wr_addr = r[7:4];
			pr.rd_addr = r[12] ? r[7:4] : r[11:8];
			nr.rd_en_a = r2[0];
			nr.rd_en_b = r2[1];
			nr.addr_a = r2[5:2];
			nr.addr_b = r2[9:6];
			drive_cycle(sel, pr, rand_data(), nr);
		end
		drive_cycle(cur_sel, '0, '0, '0);
	endtask

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display(">>> FAIL");
		$finish;
	end

	initial
	begin
		reset = 1'b1;
		ifm_sel = '0;
		prev_req = '0;
		data_in = '0;
		next_req = '0;
		repeat (2)
		begin
			@(posedge clk);
			#5;
			if (prev_rd_valid !== 1'b0 || next_rd_valid_a !== 1'b0 || next_rd_valid_b !== 1'b0)
			begin
				valid_errors++;
				$display("a valid flag is not low during reset at %0t", $time);
			end
		end
		reset = 1'b0;
		drive_cycle(2'd0, '0, '0, '0);
		fill_and_rotate();
		read_during_write();
		random_mix();
		$display("errors: %0d data, %0d valid", data_errors, valid_errors);
		if (data_errors == 0 && valid_errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

/* verilog/ifm_buffer.sv */
`timescale 1ns/100ps

module ifm_buffer (
	input  logic                       clk,
	input  logic                       reset,
	input  ifm_buffer_pkg::bank_idx_t  ifm_sel,
	input  ifm_buffer_pkg::prev_req_t  prev_req,
	input  ifm_buffer_pkg::unit_data_t data_in,
	input  ifm_buffer_pkg::next_req_t  next_req,
	output ifm_buffer_pkg::unit_data_t prev_rd_data,
	output logic                       prev_rd_valid,
	output ifm_buffer_pkg::unit_data_t next_rd_data_a,
	output ifm_buffer_pkg::unit_data_t next_rd_data_b,
	output logic                       next_rd_valid_a,
	output logic                       next_rd_valid_b
);

	ifm_buffer_pkg::bank_req_vec_t  prev_bank_req;
	ifm_buffer_pkg::bank_req_vec_t  next_bank_req;
	ifm_buffer_pkg::bank_data_vec_t bank_data;

	prev_layer_port u_prev_port (
		.clk           (clk),
		.reset         (reset),
		.ifm_sel       (ifm_sel),
		.prev_req      (prev_req),
		.bank_data     (bank_data),
		.prev_bank_req (prev_bank_req),
		.prev_rd_data  (prev_rd_data),
		.prev_rd_valid (prev_rd_valid)
	);

	next_layer_port u_next_port (
		.clk             (clk),
		.reset           (reset),
		.ifm_sel         (ifm_sel),
		.next_req        (next_req),
		.bank_data       (bank_data),
		.next_bank_req   (next_bank_req),
		.next_rd_data_a  (next_rd_data_a),
		.next_rd_data_b  (next_rd_data_b),
		.next_rd_valid_a (next_rd_valid_a),
		.next_rd_valid_b (next_rd_valid_b)
	);

	ifm_bank_array u_banks (
		.clk           (clk),
		.prev_bank_req (prev_bank_req),
		.next_bank_req (next_bank_req),
		.data_in       (data_in),
		.bank_data     (bank_data)
	);

endmodule

/* verilog/next_layer_port.sv */
`timescale 1ns/100ps

module next_layer_port (
	input  logic                           clk,
	input  logic                           reset,
	input  ifm_buffer_pkg::bank_idx_t      ifm_sel,
	input  ifm_buffer_pkg::next_req_t      next_req,
	input  ifm_buffer_pkg::bank_data_vec_t bank_data,
	output ifm_buffer_pkg::bank_req_vec_t  next_bank_req,
	output ifm_buffer_pkg::unit_data_t     next_rd_data_a,
	output ifm_buffer_pkg::unit_data_t     next_rd_data_b,
	output logic                           next_rd_valid_a,
	output logic                           next_rd_valid_b
);

	ifm_buffer_pkg::bank_idx_t  trail_bank;
	ifm_buffer_pkg::bank_idx_t  rd_bank_a;
	ifm_buffer_pkg::bank_idx_t  rd_bank_b;
	ifm_buffer_pkg::unit_data_t rd_word_a;
	ifm_buffer_pkg::unit_data_t rd_word_b;
	ifm_buffer_pkg::unit_data_t rd_hold_b;

	assign trail_bank = ifm_sel - 1'b1; // bank 0 wraps to the last bank

	always_comb
	begin
		next_bank_req = '0;
		next_bank_req[trail_bank].en_a = next_req.rd_en_a;
		next_bank_req[trail_bank].addr_a = next_req.addr_a;
		next_bank_req[trail_bank].en_b = next_req.rd_en_b;
		next_bank_req[trail_bank].addr_b = next_req.addr_b;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			rd_bank_a <= '0;
			rd_bank_b <= '0;
			next_rd_valid_a <= 1'b0;
			next_rd_valid_b <= 1'b0;
		end
		else
		begin
			next_rd_valid_a <= next_req.rd_en_a;
			next_rd_valid_b <= next_req.rd_en_b;
			if (next_req.rd_en_a)
				rd_bank_a <= trail_bank;
			if (next_req.rd_en_b)
				rd_bank_b <= trail_bank;
		end
	end

	assign rd_word_a = bank_data[rd_bank_a].a;
	assign rd_word_b = bank_data[rd_bank_b].b;

	// port B also serves previous-layer read-back once the bank rotates back
	always_ff @(posedge clk)
	begin
		if (next_rd_valid_b)
			rd_hold_b <= rd_word_b;
	end

	assign next_rd_data_a = rd_word_a; // only next-layer reads move a bank's port-A output
	assign next_rd_data_b = next_rd_valid_b ? rd_word_b : rd_hold_b;

endmodule

/* verilog/prev_layer_port.sv */
`timescale 1ns/100ps

module prev_layer_port (
	input  logic                           clk,
	input  logic                           reset,
	input  ifm_buffer_pkg::bank_idx_t      ifm_sel,
	input  ifm_buffer_pkg::prev_req_t      prev_req,
	input  ifm_buffer_pkg::bank_data_vec_t bank_data,
	output ifm_buffer_pkg::bank_req_vec_t  prev_bank_req,
	output ifm_buffer_pkg::unit_data_t     prev_rd_data,
	output logic                           prev_rd_valid
);

	ifm_buffer_pkg::bank_idx_t  rd_bank;
	ifm_buffer_pkg::unit_data_t rd_word;
	ifm_buffer_pkg::unit_data_t rd_hold;

	// writes go out on port A and read-back on port B of the current bank
	always_comb
	begin
		prev_bank_req = '0;
		prev_bank_req[ifm_sel].en_a = prev_req.wr_en;
		prev_bank_req[ifm_sel].we_a = prev_req.wr_en;
		prev_bank_req[ifm_sel].addr_a = prev_req.wr_addr;
		prev_bank_req[ifm_sel].en_b = prev_req.rd_en;
		prev_bank_req[ifm_sel].addr_b = prev_req.rd_addr;
	end

	// the bank index travels with the read so a select change cannot redirect it
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			rd_bank <= '0;
			prev_rd_valid <= 1'b0;
		end
		else
		begin
			prev_rd_valid <= prev_req.rd_en;
			if (prev_req.rd_en)
			begin
				rd_bank <= ifm_sel;
			end
		end
	end

	assign rd_word = bank_data[rd_bank].b;

	// port B of a bank is shared with the next layer later on, so keep a copy
	always_ff @(posedge clk)
	begin
		if (prev_rd_valid)
		begin
			rd_hold <= rd_word;
		end
	end

	assign prev_rd_data = prev_rd_valid ? rd_word : rd_hold;

endmodule

/* verilog/ifm_bank_array.sv */
`timescale 1ns/100ps

module ifm_bank_array (
	input  logic                           clk,
	input  ifm_buffer_pkg::bank_req_vec_t  prev_bank_req,
	input  ifm_buffer_pkg::bank_req_vec_t  next_bank_req,
	input  ifm_buffer_pkg::unit_data_t     data_in,
	output ifm_buffer_pkg::bank_data_vec_t bank_data
);

	for (genvar b = 0; b < ifm_buffer_pkg::NUM_BANKS; b++)
	begin : g_bank
		ifm_buffer_pkg::bank_req_t req;

		// the two layers never address the same bank, so an OR is a clean merge
		assign req = prev_bank_req[b] | next_bank_req[b];

		for (genvar u = 0; u < ifm_buffer_pkg::NUM_UNITS; u++)
		begin : g_unit
			ifm_unit_ram u_ram (
				.clk     (clk),
				.en_a    (req.en_a),
				.we_a    (req.we_a),
				.addr_a  (req.addr_a),
				.wdata   (data_in[u]), // each unit stores its own word
				.en_b    (req.en_b),
				.addr_b  (req.addr_b),
				.rdata_a (bank_data[b].a[u]),
				.rdata_b (bank_data[b].b[u])
			);
		end
	end

endmodule

/* verilog/ifm_unit_ram.sv */
`timescale 1ns/100ps

module ifm_unit_ram (
	input  logic                  clk,
	input  logic                  en_a,
	input  logic                  we_a,
	input  ifm_buffer_pkg::addr_t addr_a,
	input  ifm_buffer_pkg::word_t wdata,
	input  logic                  en_b,
	input  ifm_buffer_pkg::addr_t addr_b,
	output ifm_buffer_pkg::word_t rdata_a,
	output ifm_buffer_pkg::word_t rdata_b
);

	ifm_buffer_pkg::word_t mem [ifm_buffer_pkg::IFM_WORDS];

	// port A either writes or reads, a write leaves rdata_a alone
	always_ff @(posedge clk)
	begin
		if (we_a)
		begin
			mem[addr_a] <= wdata;
		end
		else if (en_a)
		begin
			rdata_a <= mem[addr_a];
		end
	end

	// a port B read of the address being written sees the old word
	always_ff @(posedge clk)
	begin
		if (en_b)
		begin
			rdata_b <= mem[addr_b];
		end
	end

endmodule

/* verilog/ifm_buffer_pkg.sv */
package ifm_buffer_pkg;

	localparam int DATA_WIDTH = 16;
	localparam int IFM_SIZE = 4;
	localparam int IFM_WORDS = IFM_SIZE * IFM_SIZE; // one word per map position
	localparam int NUM_UNITS = 3;
	localparam int NUM_BANKS = 4;

	localparam int ADDR_WIDTH = $clog2(IFM_WORDS);
	localparam int BANK_IDX_WIDTH = $clog2(NUM_BANKS);

	typedef logic [ADDR_WIDTH-1:0] addr_t;
	typedef logic [BANK_IDX_WIDTH-1:0] bank_idx_t;
	typedef logic [DATA_WIDTH-1:0] word_t;

	// unit 0 sits in the low slice
	typedef word_t [NUM_UNITS-1:0] unit_data_t;

	// previous layer writes and reads back the bank named by ifm_sel
	typedef struct packed
	{
		logic  wr_en;
		logic  rd_en;
		addr_t wr_addr;
		addr_t rd_addr;
	} prev_req_t;

	// next layer reads the trailing bank on two independent ports
	typedef struct packed
	{
		logic  rd_en_a;
		logic  rd_en_b;
		addr_t addr_a;
		addr_t addr_b;
	} next_req_t;

	// what one bank sees, all fields are zero when the bank is not addressed
	typedef struct packed
	{
		logic  en_a;
		logic  we_a;
		addr_t addr_a;
		logic  en_b;
		addr_t addr_b;
	} bank_req_t;

	typedef bank_req_t [NUM_BANKS-1:0] bank_req_vec_t;

	typedef struct packed
	{
		unit_data_t a;
		unit_data_t b;
	} bank_data_t;

	typedef bank_data_t [NUM_BANKS-1:0] bank_data_vec_t;

endpackage
